/* core.f */
+incdir+hw
hw/definitions.sv
hw/control.sv
hw/regfile.sv
hw/alu.sv
hw/mem_access.sv
hw/core.sv
tests/core_checker.sv
tests/core_tb.sv

/* hw/alu.sv */
`default_nettype none

`include "rv_defines.svh"

module alu import definitions::*; (
	input alu_op_t op_i,
	input logic [`XLEN-1:0] in1_i,
	input logic [`XLEN-1:0] in2_i,
	output logic [`XLEN-1:0] result_o
);

	logic [4:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = in2_i[4:0];
	assign lt_signed = $signed(in1_i) < $signed(in2_i);
	assign lt_unsigned = in1_i < in2_i;

	always_comb begin
		case (op_i)
		ALU_OP_ADD: result_o = in1_i + in2_i;
		ALU_OP_SUB: result_o = in1_i - in2_i;
		ALU_OP_SLL: result_o = in1_i << shamt;
		ALU_OP_SLT: result_o = {{(`XLEN-1){1'b0}}, lt_signed};
		ALU_OP_SLTU: result_o = {{(`XLEN-1){1'b0}}, lt_unsigned};
		ALU_OP_XOR: result_o = in1_i ^ in2_i;
		ALU_OP_SRL: result_o = in1_i >> shamt;
		ALU_OP_SRA: result_o = $unsigned($signed(in1_i) >>> shamt);
		ALU_OP_OR: result_o = in1_i | in2_i;
		ALU_OP_AND: result_o = in1_i & in2_i;
		ALU_OP_IN1_PASSTHROUGH: result_o = in1_i;
		ALU_OP_IN2_PASSTHROUGH: result_o = in2_i; // LUI.
		default: result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/control.sv */
`default_nettype none

module control import definitions::*; (
	input logic [31:0] ex_instr_i,
	input logic [31:0] mem_instr_i,
	input logic [31:0] wb_instr_i,
	output pipeline_ex_ctrl_t ex_ctrl_o,
	output pipeline_mem_ctrl_t mem_ctrl_o,
	output pipeline_wb_ctrl_t wb_ctrl_o
);

	opcode_t ex_opcode;
	opcode_t mem_opcode;
	opcode_t wb_opcode;
	funct3_op_t ex_funct3;
	funct3_load_t mem_load_funct3;
	funct3_store_t mem_store_funct3;
	funct3_load_t wb_load_funct3;
	logic ex_alt; // funct7[5], or imm[10] on shifts.
	alu_op_t ex_funct3_op;

	assign ex_opcode = opcode_t'(ex_instr_i[6:0]);
	assign mem_opcode = opcode_t'(mem_instr_i[6:0]);
	assign wb_opcode = opcode_t'(wb_instr_i[6:0]);
	assign ex_funct3 = funct3_op_t'(ex_instr_i[14:12]);
	assign mem_load_funct3 = funct3_load_t'(mem_instr_i[14:12]);
	assign mem_store_funct3 = funct3_store_t'(mem_instr_i[14:12]);
	assign wb_load_funct3 = funct3_load_t'(wb_instr_i[14:12]);
	assign ex_alt = ex_instr_i[30];

	// funct3 to alu op, common to OP and OP-IMM.
	always_comb begin
		case (ex_funct3)
		FUNCT3_OP_ADD_SUB: ex_funct3_op = ALU_OP_ADD;
		FUNCT3_OP_SLL: ex_funct3_op = ALU_OP_SLL;
		FUNCT3_OP_SLT: ex_funct3_op = ALU_OP_SLT;
		FUNCT3_OP_SLTU: ex_funct3_op = ALU_OP_SLTU;
		FUNCT3_OP_XOR: ex_funct3_op = ALU_OP_XOR;
		FUNCT3_OP_SR: ex_funct3_op = ex_alt ? ALU_OP_SRA : ALU_OP_SRL;
		FUNCT3_OP_OR: ex_funct3_op = ALU_OP_OR;
		default: ex_funct3_op = ALU_OP_AND;
		endcase
	end

	always_comb begin
		ex_ctrl_o.alu_op = ALU_OP_ADD; // address calc for loads and stores.
		ex_ctrl_o.alu_in1_sel = ALU_IN1_SEL_REGFILE_OUT1;
		ex_ctrl_o.alu_in2_sel = ALU_IN2_SEL_IMM;

		case (ex_opcode)
		OPCODE_LUI: ex_ctrl_o.alu_op = ALU_OP_IN2_PASSTHROUGH;
		OPCODE_AUIPC: ex_ctrl_o.alu_in1_sel = ALU_IN1_SEL_PC;
		OPCODE_OP_IMM: ex_ctrl_o.alu_op = ex_funct3_op;
		OPCODE_OP: begin
			ex_ctrl_o.alu_in2_sel = ALU_IN2_SEL_REGFILE_OUT2;
			if (ex_funct3 == FUNCT3_OP_ADD_SUB && ex_alt)
				ex_ctrl_o.alu_op = ALU_OP_SUB;
			else
				ex_ctrl_o.alu_op = ex_funct3_op;
		end
		default: ex_ctrl_o.alu_op = ALU_OP_ADD;
		endcase
	end

	always_comb begin
		mem_ctrl_o.dmem_rd_size = MEM_ACCESS_SIZE_WORD;
		mem_ctrl_o.dmem_wr_size = MEM_ACCESS_SIZE_WORD;
		mem_ctrl_o.dmem_wr_enable = 1'b0;

		if (mem_opcode == OPCODE_LOAD) begin
			case (mem_load_funct3)
			FUNCT3_LOAD_LB, FUNCT3_LOAD_LBU: mem_ctrl_o.dmem_rd_size = MEM_ACCESS_SIZE_BYTE;
			FUNCT3_LOAD_LH, FUNCT3_LOAD_LHU: mem_ctrl_o.dmem_rd_size = MEM_ACCESS_SIZE_HALF;
			default: mem_ctrl_o.dmem_rd_size = MEM_ACCESS_SIZE_WORD;
			endcase
		end else if (mem_opcode == OPCODE_STORE) begin
			mem_ctrl_o.dmem_wr_enable = 1'b1;
			case (mem_store_funct3)
			FUNCT3_STORE_SB: mem_ctrl_o.dmem_wr_size = MEM_ACCESS_SIZE_BYTE;
			FUNCT3_STORE_SH: mem_ctrl_o.dmem_wr_size = MEM_ACCESS_SIZE_HALF;
			default: mem_ctrl_o.dmem_wr_size = MEM_ACCESS_SIZE_WORD;
			endcase
		end
	end

	always_comb begin
		wb_ctrl_o.regfile_we = 1'b0;
		wb_ctrl_o.regfile_in_sel = REGFILE_IN_SEL_ALU_OUT;

		case (wb_opcode)
		OPCODE_LUI, OPCODE_AUIPC, OPCODE_OP_IMM, OPCODE_OP: wb_ctrl_o.regfile_we = 1'b1;
		OPCODE_LOAD: begin
			wb_ctrl_o.regfile_we = 1'b1;
			case (wb_load_funct3)
			FUNCT3_LOAD_LB: wb_ctrl_o.regfile_in_sel = REGFILE_IN_SEL_MEM_RD_SEXT8;
			FUNCT3_LOAD_LH: wb_ctrl_o.regfile_in_sel = REGFILE_IN_SEL_MEM_RD_SEXT16;
			default: wb_ctrl_o.regfile_in_sel = REGFILE_IN_SEL_MEM_RD;
			endcase
		end
		default: wb_ctrl_o.regfile_we = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/core.sv */
`default_nettype none

`include "rv_defines.svh"

module core import definitions::*; (
	input logic clk_i,
	input logic rst_i,
	input logic [31:0] imem_data_i,
	input logic [`XLEN-1:0] dmem_rdata_i,
	output logic [`XLEN-1:0] imem_addr_o,
	output logic [`XLEN-1:0] dmem_addr_o,
	output logic [`XLEN-1:0] dmem_wdata_o,
	output logic [3:0] dmem_be_o,
	output logic dmem_we_o,
	output logic retire_valid_o,
	output logic [4:0] retire_rd_o,
	output logic [`XLEN-1:0] retire_data_o
);

	localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0.

	logic [`XLEN-1:0] pc;

	logic [31:0] if_id_instr;
	logic [`XLEN-1:0] if_id_pc;

	logic [31:0] id_ex_instr;
	logic [`XLEN-1:0] id_ex_pc;
	logic [`XLEN-1:0] id_ex_rs1_data;
	logic [`XLEN-1:0] id_ex_rs2_data;
	logic [`XLEN-1:0] id_ex_imm;

	logic [31:0] ex_mem_instr;
	logic [`XLEN-1:0] ex_mem_alu_out;
	logic [`XLEN-1:0] ex_mem_rs2_data;

	logic [31:0] mem_wb_instr;
	logic [`XLEN-1:0] mem_wb_alu_out;
	logic [`XLEN-1:0] mem_wb_rdata;
	mem_access_size_t mem_wb_rd_size;

	pipeline_ex_ctrl_t ex_ctrl;
	pipeline_mem_ctrl_t mem_ctrl;
	pipeline_wb_ctrl_t wb_ctrl;

	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] alu_in1;
	logic [`XLEN-1:0] alu_in2;
	logic [`XLEN-1:0] alu_out;
	logic [`XLEN-1:0] load_data;
	logic [`XLEN-1:0] wb_data;

	// instruction words are the only control state.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc <= `RESET_PC;
			if_id_instr <= NOP;
			id_ex_instr <= NOP;
			ex_mem_instr <= NOP;
			mem_wb_instr <= NOP;
		end else begin
			pc <= pc + `XLEN'd4; // no branches, always pc+4.
			if_id_instr <= imem_data_i;
			id_ex_instr <= if_id_instr;
			ex_mem_instr <= id_ex_instr;
			mem_wb_instr <= ex_mem_instr;
		end
	end

	always_ff @(posedge clk_i) begin
		if_id_pc <= pc;
		id_ex_pc <= if_id_pc;
		id_ex_rs1_data <= rs1_data;
		id_ex_rs2_data <= rs2_data;
		id_ex_imm <= imm;
		ex_mem_alu_out <= alu_out;
		ex_mem_rs2_data <= id_ex_rs2_data;
		mem_wb_alu_out <= ex_mem_alu_out;
		mem_wb_rdata <= dmem_rdata_i;
		mem_wb_rd_size <= mem_ctrl.dmem_rd_size; // load formatting happens in WB.
	end

	assign imem_addr_o = pc;

	// immediate decode in ID.
	always_comb begin
		case (opcode_t'(if_id_instr[6:0]))
		OPCODE_LUI, OPCODE_AUIPC: imm = {if_id_instr[31:12], 12'b0};
		OPCODE_STORE: imm = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
		default: imm = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
		endcase
	end

	control control_inst (
		.ex_instr_i(id_ex_instr),
		.mem_instr_i(ex_mem_instr),
		.wb_instr_i(mem_wb_instr),
		.ex_ctrl_o(ex_ctrl),
		.mem_ctrl_o(mem_ctrl),
		.wb_ctrl_o(wb_ctrl)
	);

	regfile regfile_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.rs1_i(if_id_instr[19:15]),
		.rs2_i(if_id_instr[24:20]),
		.we_i(retire_valid_o),
		.rd_i(retire_rd_o),
		.wdata_i(wb_data),
		.rdata1_o(rs1_data),
		.rdata2_o(rs2_data)
	);

	assign alu_in1 = (ex_ctrl.alu_in1_sel == ALU_IN1_SEL_PC) ? id_ex_pc : id_ex_rs1_data;
	assign alu_in2 = (ex_ctrl.alu_in2_sel == ALU_IN2_SEL_IMM) ? id_ex_imm : id_ex_rs2_data;

	alu alu_inst (
		.op_i(ex_ctrl.alu_op),
		.in1_i(alu_in1),
		.in2_i(alu_in2),
		.result_o(alu_out)
	);

	assign dmem_addr_o = {ex_mem_alu_out[`XLEN-1:2], 2'b00};

	mem_access mem_access_inst (
		.wr_size_i(mem_ctrl.dmem_wr_size),
		.rd_size_i(mem_wb_rd_size),
		.wr_enable_i(mem_ctrl.dmem_wr_enable),
		.addr_i(ex_mem_alu_out[1:0]),
		.wdata_i(ex_mem_rs2_data),
		.rdata_raw_i(mem_wb_rdata),
		.rd_addr_lo_i(mem_wb_alu_out[1:0]),
		.dmem_be_o(dmem_be_o),
		.dmem_wdata_o(dmem_wdata_o),
		.dmem_we_o(dmem_we_o),
		.rdata_o(load_data)
	);

	always_comb begin
		case (wb_ctrl.regfile_in_sel)
		REGFILE_IN_SEL_MEM_RD: wb_data = load_data;
		REGFILE_IN_SEL_MEM_RD_SEXT8: wb_data = {{(`XLEN-8){load_data[7]}}, load_data[7:0]};
		REGFILE_IN_SEL_MEM_RD_SEXT16: wb_data = {{(`XLEN-16){load_data[15]}}, load_data[15:0]};
		default: wb_data = mem_wb_alu_out;
		endcase
	end

	assign retire_rd_o = mem_wb_instr[11:7];
	assign retire_valid_o = wb_ctrl.regfile_we && retire_rd_o != 5'd0;
	assign retire_data_o = wb_data;

	// loads need natural alignment too, the size comes from control.
	a_load_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
		(opcode_t'(ex_mem_instr[6:0]) == OPCODE_LOAD &&
			mem_ctrl.dmem_rd_size != MEM_ACCESS_SIZE_BYTE) |->
		(!ex_mem_alu_out[0] &&
			(mem_ctrl.dmem_rd_size != MEM_ACCESS_SIZE_WORD || !ex_mem_alu_out[1])))
		else $error("misaligned load");

	// a store in MEM reaches WB next cycle and must not write rd.
	a_store_no_retire: assert property (@(posedge clk_i) disable iff (rst_i)
		dmem_we_o |=> !retire_valid_o)
		else $error("store retired a register write");

endmodule

`default_nettype wire

/* hw/definitions.sv */
`default_nettype none

package definitions;

	typedef enum logic [6:0] {
		OPCODE_LUI    = 7'b0110111,
		OPCODE_AUIPC  = 7'b0010111,
		OPCODE_OP_IMM = 7'b0010011,
		OPCODE_OP     = 7'b0110011,
		OPCODE_LOAD   = 7'b0000011,
		OPCODE_STORE  = 7'b0100011
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_OP_ADD,
		ALU_OP_SUB,
		ALU_OP_SLL,
		ALU_OP_SLT,
		ALU_OP_SLTU,
		ALU_OP_XOR,
		ALU_OP_SRL,
		ALU_OP_SRA,
		ALU_OP_OR,
		ALU_OP_AND,
		ALU_OP_IN1_PASSTHROUGH,
		ALU_OP_IN2_PASSTHROUGH
	} alu_op_t;

	typedef enum logic {
		ALU_IN1_SEL_REGFILE_OUT1,
		ALU_IN1_SEL_PC
	} alu_in1_sel_t;

	typedef enum logic {
		ALU_IN2_SEL_REGFILE_OUT2,
		ALU_IN2_SEL_IMM
	} alu_in2_sel_t;

	typedef enum logic [1:0] {
		MEM_ACCESS_SIZE_BYTE,
		MEM_ACCESS_SIZE_HALF,
		MEM_ACCESS_SIZE_WORD
	} mem_access_size_t;

	typedef enum logic [1:0] {
		REGFILE_IN_SEL_ALU_OUT,
		REGFILE_IN_SEL_MEM_RD,
		REGFILE_IN_SEL_MEM_RD_SEXT8,
		REGFILE_IN_SEL_MEM_RD_SEXT16
	} regfile_in_sel_t;

	// shared by OP and OP-IMM, ADD_SUB is plain ADDI there.
	typedef enum logic [2:0] {
		FUNCT3_OP_ADD_SUB = 3'b000,
		FUNCT3_OP_SLL     = 3'b001,
		FUNCT3_OP_SLT     = 3'b010,
		FUNCT3_OP_SLTU    = 3'b011,
		FUNCT3_OP_XOR     = 3'b100,
		FUNCT3_OP_SR      = 3'b101,
		FUNCT3_OP_OR      = 3'b110,
		FUNCT3_OP_AND     = 3'b111
	} funct3_op_t;

	typedef enum logic [2:0] {
		FUNCT3_LOAD_LB  = 3'b000,
		FUNCT3_LOAD_LH  = 3'b001,
		FUNCT3_LOAD_LW  = 3'b010,
		FUNCT3_LOAD_LBU = 3'b100,
		FUNCT3_LOAD_LHU = 3'b101
	} funct3_load_t;

	typedef enum logic [2:0] {
		FUNCT3_STORE_SB = 3'b000,
		FUNCT3_STORE_SH = 3'b001,
		FUNCT3_STORE_SW = 3'b010
	} funct3_store_t;

	typedef struct packed {
		alu_op_t alu_op;
		alu_in1_sel_t alu_in1_sel;
		alu_in2_sel_t alu_in2_sel;
	} pipeline_ex_ctrl_t;

	typedef struct packed {
		mem_access_size_t dmem_rd_size;
		mem_access_size_t dmem_wr_size;
		logic dmem_wr_enable;
	} pipeline_mem_ctrl_t;

	typedef struct packed {
		logic regfile_we;
		regfile_in_sel_t regfile_in_sel;
	} pipeline_wb_ctrl_t;

endpackage

`default_nettype wire

/* hw/mem_access.sv */
`default_nettype none

`include "rv_defines.svh"

module mem_access import definitions::*; (
	input mem_access_size_t wr_size_i,
	input mem_access_size_t rd_size_i,
	input logic wr_enable_i,
	input logic [1:0] addr_i, // byte offset of the MEM access.
	input logic [`XLEN-1:0] wdata_i,
	input logic [`XLEN-1:0] rdata_raw_i,
	input logic [1:0] rd_addr_lo_i, // byte offset of the WB load.
	output logic [3:0] dmem_be_o,
	output logic [`XLEN-1:0] dmem_wdata_o,
	output logic dmem_we_o,
	output logic [`XLEN-1:0] rdata_o
);

	logic [3:0] be;
	logic [`XLEN-1:0] rdata_shifted;

	always_comb begin
		case (wr_size_i)
		MEM_ACCESS_SIZE_BYTE: begin
			dmem_wdata_o = {4{wdata_i[7:0]}};
			be = 4'b0001 << addr_i;
		end
		MEM_ACCESS_SIZE_HALF: begin
			dmem_wdata_o = {2{wdata_i[15:0]}};
			be = 4'b0011 << {addr_i[1], 1'b0};
		end
		default: begin
			dmem_wdata_o = wdata_i;
			be = 4'b1111;
		end
		endcase
	end

	assign dmem_be_o = wr_enable_i ? be : 4'b0000;
	assign dmem_we_o = wr_enable_i;

	// selected lane down to bit 0, then zero-extend.
	assign rdata_shifted = rdata_raw_i >> {rd_addr_lo_i, 3'b000};

	always_comb begin
		case (rd_size_i)
		MEM_ACCESS_SIZE_BYTE: rdata_o = {{(`XLEN-8){1'b0}}, rdata_shifted[7:0]};
		MEM_ACCESS_SIZE_HALF: rdata_o = {{(`XLEN-16){1'b0}}, rdata_shifted[15:0]};
		default: rdata_o = rdata_raw_i;
		endcase
	end

	always_comb begin
		if (wr_enable_i && wr_size_i != MEM_ACCESS_SIZE_BYTE)
			assert (addr_i[0] == 1'b0 && (wr_size_i != MEM_ACCESS_SIZE_WORD || !addr_i[1]))
				else $error("misaligned store");
	end

endmodule

`default_nettype wire

/* hw/regfile.sv */
`default_nettype none

`include "rv_defines.svh"

module regfile #(
	parameter int ADDR_W = $clog2(`REG_COUNT)
) (
	input logic clk_i,
	input logic rst_i,
	input logic [ADDR_W-1:0] rs1_i,
	input logic [ADDR_W-1:0] rs2_i,
	input logic we_i,
	input logic [ADDR_W-1:0] rd_i,
	input logic [`XLEN-1:0] wdata_i,
	output logic [`XLEN-1:0] rdata1_o,
	output logic [`XLEN-1:0] rdata2_o
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0; // all registers start at zero.
		end else if (we_i) begin
			regs[rd_i] <= wdata_i;
		end
	end

	// write-through, so WB and ID can share a cycle.
	assign rdata1_o = (rs1_i == '0) ? '0 :
		(we_i && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
	assign rdata2_o = (rs2_i == '0) ? '0 :
		(we_i && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

endmodule

`default_nettype wire

/* hw/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width.
`define XLEN 32

// architectural registers, x0 included.
`define REG_COUNT 32

// first fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f core.f --top-module core_tb \
	-o core_sim > build.log 2>&1 &&
./obj_dir/core_sim > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* tests/core_checker.sv */
`default_nettype none

module core_checker #(
	parameter int SEG_LEN = 40,
	parameter int SEG_COUNT = 6,
	parameter logic [31:0] BASE = 32'h0000_1000
) (
	input logic clk_i,
	input logic rst_i,
	input logic [31:0] imem_addr_i,
	input logic [31:0] imem_data_i,
	input logic [31:0] dmem_addr_i,
	input logic [31:0] dmem_wdata_i,
	input logic [3:0] dmem_be_i,
	input logic dmem_we_i,
	input logic retire_valid_i,
	input logic [4:0] retire_rd_i,
	input logic [31:0] retire_data_i,
	output logic done_o,
	output int errors_o,
	output int checks_o
);

	logic [31:0] regs [32];
	logic [31:0] mram [16];
	logic [31:0] exp_pc; // next fetch address, no branches.
	int cyc;
	int seg_next;
	int seg_err;
	int done_cyc [SEG_COUNT];
	int ret_cyc [$];
	logic [4:0] ret_rd [$];
	logic [31:0] ret_data [$];
	int st_cyc [$];
	logic [31:0] st_addr [$];
	logic [31:0] st_data [$];
	logic [3:0] st_be [$];

	// initial RAM contents, a hash of the full address.
	function logic [31:0] fill_word(input logic [31:0] a);
		return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
	endfunction

	function logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, $signed(a) < $signed(b)};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
		endcase
	endfunction

	task report_fail(input string msg);
		$display("FAIL t=%0t %s", $time, msg);
		errors_o++;
	endtask

	// architectural step, in program order at fetch.
	task model_step(input logic [31:0] ins, input logic [31:0] pc);
		logic [2:0] f3;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] addr;
		logic [31:0] lane;
		logic [31:0] res;
		logic [31:0] data;
		logic [3:0] be;
		logic we;
		f3 = ins[14:12];
		rd = ins[11:7];
		a = regs[ins[19:15]];
		b = regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		we = 1'b1;
		res = '0;
		case (ins[6:0])
		7'b0110111: res = {ins[31:12], 12'b0};
		7'b0010111: res = pc + {ins[31:12], 12'b0};
		7'b0010011: res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
		7'b0110011: res = alu_ref(f3, ins[30], a, b);
		7'b0000011: begin
			addr = a + imm_i;
			lane = mram[addr[5:2]] >> {addr[1:0], 3'b000};
			case (f3)
			3'd0: res = {{24{lane[7]}}, lane[7:0]};
			3'd1: res = {{16{lane[15]}}, lane[15:0]};
			3'd4: res = {24'b0, lane[7:0]};
			3'd5: res = {16'b0, lane[15:0]};
			default: res = lane;
			endcase
		end
		7'b0100011: begin
			we = 1'b0;
			addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
			case (f3)
			3'd0: begin
				data = {4{b[7:0]}};
				be = 4'b0001 << addr[1:0];
			end
			3'd1: begin
				data = {2{b[15:0]}};
				be = 4'b0011 << addr[1:0];
			end
			default: begin
				data = b;
				be = 4'b1111;
			end
			endcase
			for (int i = 0; i < 4; i++)
				if (be[i])
					mram[addr[5:2]][8*i +: 8] = data[8*i +: 8];
			st_cyc.push_back(cyc + 3);
			st_addr.push_back({addr[31:2], 2'b00});
			st_data.push_back(data);
			st_be.push_back(be);
		end
		default: we = 1'b0;
		endcase
		if (we && rd != 5'd0) begin
			regs[rd] = res;
			ret_cyc.push_back(cyc + 4);
			ret_rd.push_back(rd);
			ret_data.push_back(res);
		end
	endtask

	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 16; i++)
			mram[i] = fill_word(BASE + 32'(4 * i));
		for (int k = 0; k < SEG_COUNT; k++)
			done_cyc[k] = -1;
		exp_pc = '0;
		cyc = 0;
		seg_next = 0;
		seg_err = 0;
		done_o = 1'b0;
		errors_o = 0;
		checks_o = 0;
	end

	always @(negedge clk_i) begin
		if (!rst_i) begin
			if (imem_addr_i !== exp_pc)
				report_fail($sformatf("fetch from %h, expected %h", imem_addr_i, exp_pc));
			model_step(imem_data_i, exp_pc);
			for (int k = 0; k < SEG_COUNT; k++)
				if (exp_pc == 32'((k + 1) * SEG_LEN * 4 - 4))
					done_cyc[k] = cyc + 4;

			if (ret_cyc.size() > 0 && ret_cyc[0] == cyc) begin
				checks_o++;
				if (retire_valid_i !== 1'b1 || retire_rd_i !== ret_rd[0] ||
						retire_data_i !== ret_data[0])
					report_fail($sformatf("retire v=%b x%0d=%h, expected x%0d=%h",
						retire_valid_i, retire_rd_i, retire_data_i, ret_rd[0], ret_data[0]));
				void'(ret_cyc.pop_front());
				void'(ret_rd.pop_front());
				void'(ret_data.pop_front());
			end else if (retire_valid_i !== 1'b0) begin
				report_fail($sformatf("unexpected retire of x%0d", retire_rd_i));
			end

			if (st_cyc.size() > 0 && st_cyc[0] == cyc) begin
				checks_o++;
				if (dmem_we_i !== 1'b1 || dmem_addr_i !== st_addr[0] ||
						dmem_be_i !== st_be[0] || dmem_wdata_i !== st_data[0])
					report_fail($sformatf("store @%h be %b data %h, expected @%h be %b data %h",
						dmem_addr_i, dmem_be_i, dmem_wdata_i, st_addr[0], st_be[0], st_data[0]));
				void'(st_cyc.pop_front());
				void'(st_addr.pop_front());
				void'(st_data.pop_front());
				void'(st_be.pop_front());
			end else if (dmem_we_i !== 1'b0) begin
				report_fail($sformatf("unexpected store to %h", dmem_addr_i));
			end

			if (seg_next < SEG_COUNT && done_cyc[seg_next] == cyc) begin
				$display("test %0d done at t=%0t, %0d errors", seg_next + 1, $time,
					errors_o - seg_err);
				seg_err = errors_o;
				seg_next++;
				if (seg_next == SEG_COUNT)
					done_o = 1'b1;
			end
			exp_pc = exp_pc + 32'd4;
			cyc++;
		end
	end

endmodule

`default_nettype wire

/* tests/core_tb.sv */
`default_nettype none

module core_tb;

	localparam int SEG_LEN = 40;
	localparam int SEG_COUNT = 6;
	localparam int TOTAL = SEG_LEN * SEG_COUNT;
	localparam int TIMEOUT = TOTAL + 20;
	localparam logic [31:0] BASE = 32'h0000_1000;
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic clk_i = 1'b0;
	logic rst_i = 1'b1;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_data_i;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_rdata_i;
	logic [31:0] dmem_wdata_o;
	logic [3:0] dmem_be_o;
	logic dmem_we_o;
	logic retire_valid_o;
	logic [4:0] retire_rd_o;
	logic [31:0] retire_data_o;
	logic done;
	int errors;
	int checks;
	int cycles = 0;

	logic [31:0] rom [TOTAL];
	logic [31:0] ram [16]; // 64-byte window at BASE.
	logic [31:0] lcg_state;
	logic [4:0] recent [3]; // last three destinations.

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) cycles <= cycles + 1;

	assign imem_data_i = (imem_addr_o[31:2] < TOTAL) ? rom[imem_addr_o[31:2]] : NOP;
	assign dmem_rdata_i = ram[dmem_addr_o[5:2]];

	always @(posedge clk_i) begin
		if (dmem_we_o && dmem_be_o[0]) ram[dmem_addr_o[5:2]][7:0] <= dmem_wdata_o[7:0];
		if (dmem_we_o && dmem_be_o[1]) ram[dmem_addr_o[5:2]][15:8] <= dmem_wdata_o[15:8];
		if (dmem_we_o && dmem_be_o[2]) ram[dmem_addr_o[5:2]][23:16] <= dmem_wdata_o[23:16];
		if (dmem_we_o && dmem_be_o[3]) ram[dmem_addr_o[5:2]][31:24] <= dmem_wdata_o[31:24];
	end

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:16]) % n;
	endfunction

	function logic [4:0] pick_src();
		logic [4:0] r;
		r = 5'(rand_below(16));
		while (r != 0 && (r == recent[0] || r == recent[1] || r == recent[2]))
			r = 5'(rand_below(16));
		return r;
	endfunction

	function logic [4:0] pick_dest();
		return 5'(2 + rand_below(14)); // x1 holds the RAM base.
	endfunction

	function void push_dest(input logic [4:0] rd);
		recent[2] = recent[1];
		recent[1] = recent[0];
		recent[0] = rd;
	endfunction

	function logic [31:0] make_instr(input int test);
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [11:0] imm;
		logic [31:0] ins;
		int sz;
		f3 = 3'(rand_below(8));
		rs1 = pick_src();
		rs2 = pick_src();
		rd = pick_dest();
		imm = 12'(next_rand() >> 7);
		case (test)
		0: ins = {imm, rs1, 3'b000, rd, 7'b0010011};
		1: ins = {(f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1 ? 7'h20 : 7'h00,
			rs2, rs1, f3, rd, 7'b0110011};
		2: begin
			if (f3 == 3'd1 || f3 == 3'd5)
				imm = {1'b0, f3 == 3'd5 && rand_below(2) == 1, 5'b0, imm[4:0]};
			ins = {imm, rs1, f3, rd, 7'b0010011};
		end
		3: ins = {20'(next_rand() >> 9), rd, rand_below(2) == 1 ? 7'b0010111 : 7'b0110111};
		4: begin
			sz = 1 << rand_below(3);
			imm = 12'(rand_below(64) & ~(sz - 1));
			f3 = (sz == 4) ? 3'd2 : (sz == 2) ? 3'd1 : 3'd0;
			if (rand_below(2) == 1) begin
				ins = {imm[11:5], rs2, 5'd1, f3, imm[4:0], 7'b0100011};
				rd = 5'd0; // stores write nothing.
			end else begin
				if (sz < 4 && rand_below(2) == 1)
					f3 = f3 | 3'b100; // unsigned variant.
				ins = {imm, 5'd1, f3, rd, 7'b0000011};
			end
		end
		default: begin
			if (rand_below(2) == 1)
				rd = 5'd0;
			if (rand_below(2) == 1)
				ins = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
			else
				ins = {imm, 5'd0, 3'b000, rd, 7'b0010011};
		end
		endcase
		push_dest(rd);
		return ins;
	endfunction

	task build_program();
		int base;
		for (int k = 0; k < SEG_COUNT; k++) begin
			base = k * SEG_LEN;
			rom[base] = {BASE[31:12], 5'd1, 7'b0110111}; // lui x1.
			push_dest(5'd1);
			for (int i = 1; i < 4; i++) begin
				rom[base + i] = NOP;
				push_dest(5'd0);
			end
			for (int i = 4; i < SEG_LEN - 4; i++)
				rom[base + i] = make_instr(k);
			for (int i = SEG_LEN - 4; i < SEG_LEN; i++) begin
				rom[base + i] = NOP;
				push_dest(5'd0);
			end
		end
	endtask

	core core_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.imem_data_i(imem_data_i),
		.dmem_rdata_i(dmem_rdata_i),
		.imem_addr_o(imem_addr_o),
		.dmem_addr_o(dmem_addr_o),
		.dmem_wdata_o(dmem_wdata_o),
		.dmem_be_o(dmem_be_o),
		.dmem_we_o(dmem_we_o),
		.retire_valid_o(retire_valid_o),
		.retire_rd_o(retire_rd_o),
		.retire_data_o(retire_data_o)
	);

	core_checker #(
		.SEG_LEN(SEG_LEN),
		.SEG_COUNT(SEG_COUNT),
		.BASE(BASE)
	) checker_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.imem_addr_i(imem_addr_o),
		.imem_data_i(imem_data_i),
		.dmem_addr_i(dmem_addr_o),
		.dmem_wdata_i(dmem_wdata_o),
		.dmem_be_i(dmem_be_o),
		.dmem_we_i(dmem_we_o),
		.retire_valid_i(retire_valid_o),
		.retire_rd_i(retire_rd_o),
		.retire_data_i(retire_data_o),
		.done_o(done),
		.errors_o(errors),
		.checks_o(checks)
	);

	initial begin
		lcg_state = 32'd84248;
		recent[0] = 5'd0;
		recent[1] = 5'd0;
		recent[2] = 5'd0;
		build_program();
		for (int i = 0; i < 16; i++)
			ram[i] = checker_inst.fill_word(BASE + 32'(4 * i));
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;
		while (!done && cycles < TIMEOUT)
			@(posedge clk_i);
		if (!done)
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (done && errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
